// ==== decode_top.f ====
+incdir+.
isa_pkg.sv
pipe_pkg.sv
if_id_reg.sv
inst_decoder.sv
branch_unit.sv
issue_control.sv
exe_packer.sv
decode_top.sv
tb_decode_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_decode_top
FILELIST  ?= decode_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= sim passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== tb_decode_top.sv ====
`timescale 1ns/10ps
`include "mips_defines.svh"

module tb_decode_top;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 5;
    localparam int MAX_WAIT     = 8;    // stall cycles allowed per decode
    localparam int HOLD_CYCLES  = 3;
    localparam int ISSUE_COUNT  = 47;   // instructions strobed over all tests
    localparam int RUN_CYCLES   = RESET_CYCLES + 2 + ISSUE_COUNT * (MAX_WAIT + 3)
                                + 2 * HOLD_CYCLES + 10;

    // one-hot alu ops with add at the msb
    localparam logic [11:0] ALU_ADD = 12'h800;
    localparam logic [11:0] ALU_SUB = 12'h400;
    localparam logic [11:0] ALU_SLT = 12'h200;
    localparam logic [11:0] ALU_AND = 12'h080;
    localparam logic [11:0] ALU_NOR = 12'h040;
    localparam logic [11:0] ALU_SLL = 12'h008;
    localparam logic [11:0] ALU_SRA = 12'h002;
    localparam logic [11:0] ALU_LUI = 12'h001;

    logic                 clk;
    logic                 arst_n;
    logic                 fetch_valid;
    pipe_pkg::fetch_bus_t fetch;
    logic                 if_over;
    isa_pkg::word_t       rs_value;
    isa_pkg::word_t       rt_value;
    isa_pkg::reg_addr_t   exe_wdest;
    isa_pkg::reg_addr_t   mem_wdest;
    isa_pkg::reg_addr_t   wb_wdest;
    isa_pkg::reg_addr_t   rs;
    isa_pkg::reg_addr_t   rt;
    logic                 id_allow_in;
    logic                 id_over;
    pipe_pkg::jbr_bus_t   jbr;
    pipe_pkg::exe_bus_t   exe_bus;
    integer               seed = 35;
    int                   checks = 0;
    int                   errors = 0;
    string                branch_names [6] = '{"beq", "bne", "bgez", "bgtz", "blez", "bltz"};

    decode_top i_dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .fetch_valid (fetch_valid),
        .fetch       (fetch),
        .if_over     (if_over),
        .rs_value    (rs_value),
        .rt_value    (rt_value),
        .exe_wdest   (exe_wdest),
        .mem_wdest   (mem_wdest),
        .wb_wdest    (wb_wdest),
        .rs          (rs),
        .rt          (rt),
        .id_allow_in (id_allow_in),
        .id_over     (id_over),
        .jbr         (jbr),
        .exe_bus     (exe_bus)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("sim failed");
        $finish;
    end

    // **************************************************
    // helpers
    // **************************************************
    function automatic isa_pkg::word_t r_type(input logic [4:0] rs_n, input logic [4:0] rt_n,
                                              input logic [4:0] rd_n, input logic [4:0] sa_n,
                                              input logic [5:0] fn);
        return {`OP_SPECIAL, rs_n, rt_n, rd_n, sa_n, fn};
    endfunction

    function automatic isa_pkg::word_t i_type(input logic [5:0] op, input logic [4:0] rs_n,
                                              input logic [4:0] rt_n, input logic [15:0] imm);
        return {op, rs_n, rt_n, imm};
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_exe(input string name, input logic [11:0] alu, input isa_pkg::word_t op1,
                             input isa_pkg::word_t op2, input logic wen, input logic [4:0] wdest);
        check_val({name, " alu_op"}, 32'(alu), 32'(exe_bus.alu_op));
        check_val({name, " operand1"}, op1, exe_bus.operand1);
        check_val({name, " operand2"}, op2, exe_bus.operand2);
        check_val({name, " rf_wen"}, 32'(wen), 32'(exe_bus.rf_wen));
        check_val({name, " rf_wdest"}, 32'(wdest), 32'(exe_bus.rf_wdest));
    endtask

    // register read numbers sent to the register file
    task automatic check_srcs(input string name, input logic [4:0] exp_rs,
                              input logic [4:0] exp_rt);
        check_val({name, " rs"}, 32'(exp_rs), 32'(rs));
        check_val({name, " rt"}, 32'(exp_rt), 32'(rt));
    endtask

    // one-cycle strobe that also sets the read values
    task automatic strobe(input isa_pkg::word_t pc, input isa_pkg::word_t inst,
                          input isa_pkg::word_t a, input isa_pkg::word_t b);
        @(negedge clk);
        fetch_valid = 1'b1;
        fetch.pc    = pc;
        fetch.inst  = inst;
        rs_value    = a;
        rt_value    = b;
        @(negedge clk);
        fetch_valid = 1'b0;
    endtask

    // samples on rising edges until id_over
    task automatic wait_over(input string name, output int stalls);
        stalls = 0;
        @(posedge clk);
        while (!id_over && stalls < MAX_WAIT) begin
            stalls++;
            @(posedge clk);
        end
        if (!id_over) begin
            errors++;
            $display("%s: decode did not complete within %0d cycles", name, MAX_WAIT);
        end
    endtask

    task automatic run_inst(input string name, input isa_pkg::word_t pc, input isa_pkg::word_t inst,
                            input isa_pkg::word_t a, input isa_pkg::word_t b);
        int stalls;
        strobe(pc, inst, a, b);
        wait_over(name, stalls);
        check_val({name, " stall cycles"}, 32'd0, 32'(stalls));
    endtask

    // **************************************************
    // directed tests
    // **************************************************
    task automatic test_reg_alu();
        isa_pkg::word_t a;
        isa_pkg::word_t b;
        a = $random(seed);
        b = $random(seed);
        run_inst("addu", 32'h0040_0000, r_type(5'd1, 5'd2, 5'd3, 5'd0, `FN_ADDU), a, b);
        check_exe("addu", ALU_ADD, a, b, 1'b1, 5'd3);
        check_srcs("addu", 5'd1, 5'd2);
        run_inst("subu", 32'h0040_0004, r_type(5'd4, 5'd5, 5'd6, 5'd0, `FN_SUBU), a, b);
        check_exe("subu", ALU_SUB, a, b, 1'b1, 5'd6);
        run_inst("nor", 32'h0040_0008, r_type(5'd7, 5'd8, 5'd9, 5'd0, `FN_NOR), a, b);
        check_exe("nor", ALU_NOR, a, b, 1'b1, 5'd9);
        check_srcs("nor", 5'd7, 5'd8);
        run_inst("sllv", 32'h0040_000c, r_type(5'd5, 5'd6, 5'd7, 5'd0, `FN_SLLV), a, b);
        check_exe("sllv", ALU_SLL, a, b, 1'b1, 5'd7);
        run_inst("sra", 32'h0040_0010, r_type(5'd0, 5'd2, 5'd4, 5'd7, `FN_SRA), a, b);
        check_exe("sra", ALU_SRA, 32'd7, b, 1'b1, 5'd4);   // shift amount from sa
        check_srcs("sra", 5'd0, 5'd2);
    endtask

    task automatic test_immediates();
        isa_pkg::word_t a;
        isa_pkg::word_t b;
        a = $random(seed);
        b = $random(seed);
        run_inst("addiu", 32'h0040_0100, i_type(`OP_ADDIU, 5'd1, 5'd10, 16'h8004), a, b);
        check_exe("addiu", ALU_ADD, a, 32'hffff_8004, 1'b1, 5'd10);
        check_srcs("addiu", 5'd1, 5'd10);
        run_inst("slti", 32'h0040_0104, i_type(`OP_SLTI, 5'd2, 5'd11, 16'hfffe), a, b);
        check_exe("slti", ALU_SLT, a, 32'hffff_fffe, 1'b1, 5'd11);
        run_inst("andi", 32'h0040_0108, i_type(`OP_ANDI, 5'd3, 5'd12, 16'hf0f0), a, b);
        check_exe("andi", ALU_AND, a, 32'h0000_f0f0, 1'b1, 5'd12);
        run_inst("lui", 32'h0040_010c, i_type(`OP_LUI, 5'd0, 5'd13, 16'h9234), a, b);
        check_exe("lui", ALU_LUI, a, 32'h0000_9234, 1'b1, 5'd13);
    endtask

    task automatic test_branches();
        isa_pkg::word_t pc;
        isa_pkg::word_t a;
        isa_pkg::word_t b;
        isa_pkg::word_t inst;
        isa_pkg::word_t offs;
        logic [15:0]    off;
        logic           exp_taken;
        string          name;
        for (int k = 0; k < 6; k++) begin
            for (int v = 0; v < 5; v++) begin
                name = $sformatf("%s case %0d", branch_names[k], v);
                a    = $random(seed);
                b    = $random(seed);
                off  = 16'($random(seed));
                pc   = $random(seed);
                pc[1:0] = 2'b00;
                case (v)   // boundary values of rs
                    1: b = a;
                    2: a = '0;
                    3: a = 32'h8000_0000;
                    4: a = 32'd1;
                    default: ;
                endcase
                case (k)
                    0: inst = i_type(`OP_BEQ, 5'd8, 5'd9, off);
                    1: inst = i_type(`OP_BNE, 5'd8, 5'd9, off);
                    2: inst = i_type(`OP_REGIMM, 5'd8, `RT_BGEZ, off);
                    3: inst = i_type(`OP_BGTZ, 5'd8, 5'd0, off);
                    4: inst = i_type(`OP_BLEZ, 5'd8, 5'd0, off);
                    default: inst = i_type(`OP_REGIMM, 5'd8, `RT_BLTZ, off);
                endcase
                case (k)
                    0: exp_taken = (a == b);
                    1: exp_taken = (a != b);
                    2: exp_taken = ($signed(a) >= 0);
                    3: exp_taken = ($signed(a) > 0);
                    4: exp_taken = ($signed(a) <= 0);
                    default: exp_taken = ($signed(a) < 0);
                endcase
                offs = 32'($signed(off));
                run_inst(name, pc, inst, a, b);
                check_val({name, " taken"}, 32'(exp_taken), 32'(jbr.taken));
                check_val({name, " target"}, pc + 32'd4 + offs * 32'd4, jbr.target);
                check_val({name, " rf_wen"}, 32'd0, 32'(exe_bus.rf_wen));
            end
        end
    endtask

    task automatic test_jumps();
        isa_pkg::word_t pc;
        isa_pkg::word_t pc4;
        isa_pkg::word_t a;
        isa_pkg::word_t b;
        pc  = 32'hb234_5670;
        pc4 = pc + 32'd4;
        a   = $random(seed);
        b   = $random(seed);
        a[1:0] = 2'b00;
        run_inst("j", pc, {`OP_J, 26'h2ab_cdef}, a, b);
        check_val("j taken", 32'd1, 32'(jbr.taken));
        check_val("j target", {pc4[31:28], 26'h2ab_cdef, 2'b00}, jbr.target);
        check_val("j rf_wen", 32'd0, 32'(exe_bus.rf_wen));
        run_inst("jal", pc, {`OP_JAL, 26'h155_1234}, a, b);
        check_val("jal taken", 32'd1, 32'(jbr.taken));
        check_val("jal target", {pc4[31:28], 26'h155_1234, 2'b00}, jbr.target);
        check_exe("jal", ALU_ADD, pc, 32'd8, 1'b1, 5'd31);
        run_inst("jr", pc, r_type(5'd9, 5'd0, 5'd0, 5'd0, `FN_JR), a, b);
        check_val("jr taken", 32'd1, 32'(jbr.taken));
        check_val("jr target", a, jbr.target);
        check_val("jr rf_wen", 32'd0, 32'(exe_bus.rf_wen));
        check_srcs("jr", 5'd9, 5'd0);
        run_inst("jalr", pc, r_type(5'd9, 5'd0, 5'd5, 5'd0, `FN_JALR), a, b);
        check_val("jalr taken", 32'd1, 32'(jbr.taken));
        check_val("jalr target", a, jbr.target);
        check_exe("jalr", ALU_ADD, pc, 32'd8, 1'b1, 5'd5);
    endtask

    task automatic test_hazards();
        isa_pkg::word_t a;
        isa_pkg::word_t b;
        int             stalls;
        a = $random(seed);
        b = $random(seed);
        @(negedge clk);
        exe_wdest = 5'd4;   // rs pending in exe
        strobe(32'h0040_0200, r_type(5'd4, 5'd2, 5'd3, 5'd0, `FN_ADDU), a, b);
        repeat (HOLD_CYCLES) begin
            @(posedge clk);
            if (id_over || id_allow_in) begin
                errors++;
                $display("hazard on rs did not hold the instruction in decode");
            end
        end
        @(negedge clk);
        exe_wdest = 5'd0;
        wait_over("hazard release", stalls);
        check_val("hazard release stall cycles", 32'd0, 32'(stalls));
        check_val("hazard release id_allow_in", 32'd1, 32'(id_allow_in));
        check_val("hazard release rf_wdest", 32'd3, 32'(exe_bus.rf_wdest));
        run_inst("r0 source", 32'h0040_0204, r_type(5'd0, 5'd0, 5'd3, 5'd0, `FN_ADDU), a, b);
        check_exe("r0 source", ALU_ADD, a, b, 1'b1, 5'd3);
        @(negedge clk);
        mem_wdest = 5'd6;   // matches the dest field only
        run_inst("addiu rt pending", 32'h0040_0208, i_type(`OP_ADDIU, 5'd1, 5'd6, 16'h0010), a, b);
        check_exe("addiu rt pending", ALU_ADD, a, 32'h0000_0010, 1'b1, 5'd6);
        @(negedge clk);
        mem_wdest = 5'd0;
    endtask

    task automatic test_branch_hold();
        isa_pkg::word_t a;
        int             stalls;
        a = $random(seed);
        @(negedge clk);
        if_over = 1'b0;
        strobe(32'h0040_0300, i_type(`OP_BEQ, 5'd8, 5'd9, 16'h0003), a, a);
        repeat (HOLD_CYCLES) begin
            @(posedge clk);
            if (id_over || jbr.taken) begin
                errors++;
                $display("branch completed before fetch finished");
            end
        end
        @(negedge clk);
        if_over = 1'b1;
        wait_over("branch hold", stalls);
        check_val("branch hold stall cycles", 32'd0, 32'(stalls));
        check_val("branch hold taken", 32'd1, 32'(jbr.taken));
        check_val("branch hold target", 32'h0040_0310, jbr.target);
    endtask

    // **************************************************
    // main sequence
    // **************************************************
    initial begin
        arst_n      = 1'b0;
        fetch_valid = 1'b0;
        fetch       = '0;
        if_over     = 1'b1;
        rs_value    = '0;
        rt_value    = '0;
        exe_wdest   = '0;
        mem_wdest   = '0;
        wb_wdest    = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(posedge clk);
        check_val("reset id_over", 32'd0, 32'(id_over));
        check_val("reset jbr.taken", 32'd0, 32'(jbr.taken));
        check_val("reset id_allow_in", 32'd1, 32'(id_allow_in));
        test_reg_alu();
        test_immediates();
        test_branches();
        test_jumps();
        test_hazards();
        test_branch_hold();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== decode_top.sv ====
`timescale 1ns/10ps
`include "mips_defines.svh"

module decode_top (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 fetch_valid,
    input  pipe_pkg::fetch_bus_t fetch,
    input  logic                 if_over,
    input  isa_pkg::word_t       rs_value,
    input  isa_pkg::word_t       rt_value,
    input  isa_pkg::reg_addr_t   exe_wdest,
    input  isa_pkg::reg_addr_t   mem_wdest,
    input  isa_pkg::reg_addr_t   wb_wdest,
    output isa_pkg::reg_addr_t   rs,
    output isa_pkg::reg_addr_t   rt,
    output logic                 id_allow_in,
    output logic                 id_over,
    output pipe_pkg::jbr_bus_t   jbr,
    output pipe_pkg::exe_bus_t   exe_bus
);

    logic                 id_valid;
    pipe_pkg::fetch_bus_t id_inst;
    isa_pkg::reg_addr_t   rd;
    isa_pkg::reg_addr_t   sa;
    isa_pkg::imm_t        imm;
    logic [`TARGET_W-1:0] target;
    pipe_pkg::dec_info_t  dec;

    if_id_reg i_if_id_reg (
        .clk         (clk),
        .arst_n      (arst_n),
        .fetch_valid (fetch_valid),
        .fetch       (fetch),
        .id_over     (id_over),
        .id_valid    (id_valid),
        .id_inst     (id_inst),
        .id_allow_in (id_allow_in)
    );

    inst_decoder i_inst_decoder (
        .inst   (id_inst.inst),
        .rs     (rs),
        .rt     (rt),
        .rd     (rd),
        .sa     (sa),
        .imm    (imm),
        .target (target),
        .dec    (dec)
    );

    branch_unit i_branch_unit (
        .dec      (dec),
        .pc       (id_inst.pc),
        .target   (target),
        .imm      (imm),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .id_over  (id_over),
        .jbr      (jbr)
    );

    issue_control i_issue_control (
        .id_valid  (id_valid),
        .if_over   (if_over),
        .dec       (dec),
        .rs        (rs),
        .rt        (rt),
        .exe_wdest (exe_wdest),
        .mem_wdest (mem_wdest),
        .wb_wdest  (wb_wdest),
        .id_over   (id_over)
    );

    exe_packer i_exe_packer (
        .dec      (dec),
        .pc       (id_inst.pc),
        .sa       (sa),
        .imm      (imm),
        .rt       (rt),
        .rd       (rd),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .exe_bus  (exe_bus)
    );

endmodule

// ==== exe_packer.sv ====
`timescale 1ns/10ps
`include "mips_defines.svh"

module exe_packer (
    input  pipe_pkg::dec_info_t dec,
    input  isa_pkg::word_t      pc,
    input  isa_pkg::reg_addr_t  sa,
    input  isa_pkg::imm_t       imm,
    input  isa_pkg::reg_addr_t  rt,
    input  isa_pkg::reg_addr_t  rd,
    input  isa_pkg::word_t      rs_value,
    input  isa_pkg::word_t      rt_value,
    output pipe_pkg::exe_bus_t  exe_bus
);

    logic rf_wen;

    assign exe_bus.alu_op = dec.alu_op;

    // link computes pc + 8 in the alu
    assign exe_bus.operand1 = dec.link     ? pc
                            : dec.shift_sa ? {{(`DATA_W-`REG_ADDR_W){1'b0}}, sa}
                            : rs_value;

    assign exe_bus.operand2 = dec.link     ? isa_pkg::word_t'(`LINK_OFFSET)
                            : dec.imm_zero ? {16'd0, imm}
                            : dec.imm_sign ? {{16{imm[15]}}, imm}
                            : rt_value;

    assign rf_wen = dec.wdest_rt | dec.wdest_31 | dec.wdest_rd;

    assign exe_bus.rf_wen   = rf_wen;
    assign exe_bus.rf_wdest = dec.wdest_rt ? rt
                            : dec.wdest_31 ? isa_pkg::reg_addr_t'(`LINK_REG)
                            : dec.wdest_rd ? rd
                            : '0;   // 0 keeps later hazard compares clean

endmodule

// ==== issue_control.sv ====
`timescale 1ns/10ps

module issue_control (
    input  logic                id_valid,
    input  logic                if_over,
    input  pipe_pkg::dec_info_t dec,
    input  isa_pkg::reg_addr_t  rs,
    input  isa_pkg::reg_addr_t  rt,
    input  isa_pkg::reg_addr_t  exe_wdest,
    input  isa_pkg::reg_addr_t  mem_wdest,
    input  isa_pkg::reg_addr_t  wb_wdest,
    output logic                id_over
);

    logic rs_wait;
    logic rt_wait;
    logic is_jbr;

    // r0 is never written, so it never waits
    function automatic logic pending(input isa_pkg::reg_addr_t src,
                                     input isa_pkg::reg_addr_t d_exe,
                                     input isa_pkg::reg_addr_t d_mem,
                                     input isa_pkg::reg_addr_t d_wb);
        return (src != '0) & ((src == d_exe) | (src == d_mem) | (src == d_wb));
    endfunction

    assign rs_wait = pending(rs, exe_wdest, mem_wdest, wb_wdest);
    assign rt_wait = ~dec.no_rt & pending(rt, exe_wdest, mem_wdest, wb_wdest);

    assign is_jbr = dec.jump_abs | dec.jump_reg | dec.beq | dec.bne
                  | dec.bgez | dec.bgtz | dec.blez | dec.bltz;

    // a jump must wait for fetch to finish, otherwise the redirect is lost
    assign id_over = id_valid & ~rs_wait & ~rt_wait & (~is_jbr | if_over);

endmodule

// ==== branch_unit.sv ====
`timescale 1ns/10ps
`include "mips_defines.svh"

module branch_unit (
    input  pipe_pkg::dec_info_t  dec,
    input  isa_pkg::word_t       pc,
    input  logic [`TARGET_W-1:0] target,
    input  isa_pkg::imm_t        imm,
    input  isa_pkg::word_t       rs_value,
    input  isa_pkg::word_t       rt_value,
    input  logic                 id_over,
    output pipe_pkg::jbr_bus_t   jbr
);

    isa_pkg::word_t bd_pc;       // delay-slot pc
    isa_pkg::word_t j_target;
    isa_pkg::word_t br_target;
    logic           j_taken;
    logic           br_taken;
    logic           rs_eq_rt;
    logic           rs_ez;
    logic           rs_ltz;

    assign bd_pc = pc + 32'd4;

    // **************************************************
    // jumps
    // **************************************************
    assign j_taken  = dec.jump_abs | dec.jump_reg;
    assign j_target = dec.jump_reg ? rs_value : {bd_pc[31:28], target, 2'b00};

    // **************************************************
    // conditional branches
    // **************************************************
    assign rs_eq_rt = (rs_value == rt_value);
    assign rs_ez    = (rs_value == '0);
    assign rs_ltz   = rs_value[`DATA_W-1];   // sign bit

    assign br_taken = (dec.beq  & rs_eq_rt)
                    | (dec.bne  & ~rs_eq_rt)
                    | (dec.bgez & ~rs_ltz)
                    | (dec.bgtz & ~rs_ltz & ~rs_ez)
                    | (dec.blez & (rs_ltz | rs_ez))
                    | (dec.bltz & rs_ltz);

    assign br_target = bd_pc + {{14{imm[15]}}, imm, 2'b00};   // offset in words

    // redirect only once decode is done with it
    assign jbr.taken  = (j_taken | br_taken) & id_over;
    assign jbr.target = j_taken ? j_target : br_target;

endmodule

// ==== inst_decoder.sv ====
`timescale 1ns/10ps
`include "mips_defines.svh"

module inst_decoder (
    input  isa_pkg::word_t       inst,
    output isa_pkg::reg_addr_t   rs,
    output isa_pkg::reg_addr_t   rt,
    output isa_pkg::reg_addr_t   rd,
    output isa_pkg::reg_addr_t   sa,
    output isa_pkg::imm_t        imm,
    output logic [`TARGET_W-1:0] target,
    output pipe_pkg::dec_info_t  dec
);

    isa_pkg::opcode_t op;
    isa_pkg::funct_t  funct;
    logic             special;
    logic             sa_zero;
    logic             rs_zero;
    logic             rt_zero;

    assign op     = inst[31:26];
    assign rs     = inst[25:21];
    assign rt     = inst[20:16];
    assign rd     = inst[15:11];
    assign sa     = inst[10:6];
    assign funct  = inst[5:0];
    assign imm    = inst[15:0];
    assign target = inst[25:0];

    assign special = (op == `OP_SPECIAL);
    assign sa_zero = (sa == '0);
    assign rs_zero = (rs == '0);
    assign rt_zero = (rt == '0);

    // **************************************************
    // match terms
    // **************************************************
    logic i_addu, i_subu, i_slt, i_sltu, i_and, i_nor, i_or, i_xor;
    logic i_sll, i_srl, i_sra, i_sllv, i_srlv, i_srav, i_jr, i_jalr;
    logic i_addiu, i_slti, i_sltiu, i_andi, i_ori, i_xori, i_lui;
    logic i_beq, i_bne, i_bgez, i_bgtz, i_blez, i_bltz, i_j, i_jal;

    assign i_addu  = special & sa_zero & (funct == `FN_ADDU);
    assign i_subu  = special & sa_zero & (funct == `FN_SUBU);
    assign i_slt   = special & sa_zero & (funct == `FN_SLT);
    assign i_sltu  = special & sa_zero & (funct == `FN_SLTU);
    assign i_and   = special & sa_zero & (funct == `FN_AND);
    assign i_nor   = special & sa_zero & (funct == `FN_NOR);
    assign i_or    = special & sa_zero & (funct == `FN_OR);
    assign i_xor   = special & sa_zero & (funct == `FN_XOR);
    assign i_sll   = special & rs_zero & (funct == `FN_SLL);   // sll 0,0,0 is nop
    assign i_srl   = special & rs_zero & (funct == `FN_SRL);
    assign i_sra   = special & rs_zero & (funct == `FN_SRA);
    assign i_sllv  = special & sa_zero & (funct == `FN_SLLV);
    assign i_srlv  = special & sa_zero & (funct == `FN_SRLV);
    assign i_srav  = special & sa_zero & (funct == `FN_SRAV);
    assign i_jr    = special & rt_zero & (rd == '0) & sa_zero & (funct == `FN_JR);
    assign i_jalr  = special & rt_zero & sa_zero & (funct == `FN_JALR);

    assign i_addiu = (op == `OP_ADDIU);
    assign i_slti  = (op == `OP_SLTI);
    assign i_sltiu = (op == `OP_SLTIU);
    assign i_andi  = (op == `OP_ANDI);
    assign i_ori   = (op == `OP_ORI);
    assign i_xori  = (op == `OP_XORI);
    assign i_lui   = (op == `OP_LUI) & rs_zero;
    assign i_beq   = (op == `OP_BEQ);
    assign i_bne   = (op == `OP_BNE);
    assign i_bgez  = (op == `OP_REGIMM) & (rt == `RT_BGEZ);
    assign i_bltz  = (op == `OP_REGIMM) & (rt == `RT_BLTZ);
    assign i_bgtz  = (op == `OP_BGTZ) & rt_zero;
    assign i_blez  = (op == `OP_BLEZ) & rt_zero;
    assign i_j     = (op == `OP_J);
    assign i_jal   = (op == `OP_JAL);

    // **************************************************
    // class flags
    // **************************************************
    always_comb begin
        dec.alu_op   = {i_addu | i_addiu | i_jal | i_jalr,   // link adds pc+8
                        i_subu,
                        i_slt  | i_slti,
                        i_sltu | i_sltiu,
                        i_and  | i_andi,
                        i_nor,
                        i_or   | i_ori,
                        i_xor  | i_xori,
                        i_sll  | i_sllv,
                        i_srl  | i_srlv,
                        i_sra  | i_srav,
                        i_lui};
        dec.imm_zero = i_andi | i_ori | i_xori | i_lui;
        dec.imm_sign = i_addiu | i_slti | i_sltiu;
        dec.shift_sa = i_sll | i_srl | i_sra;
        dec.link     = i_jal | i_jalr;
        dec.jump_reg = i_jr | i_jalr;
        dec.jump_abs = i_j | i_jal;
        dec.beq      = i_beq;
        dec.bne      = i_bne;
        dec.bgez     = i_bgez;
        dec.bgtz     = i_bgtz;
        dec.blez     = i_blez;
        dec.bltz     = i_bltz;
        dec.wdest_rt = dec.imm_zero | dec.imm_sign;
        dec.wdest_31 = i_jal;
        dec.wdest_rd = i_addu | i_subu | i_slt | i_sltu | i_and | i_nor | i_or
                     | i_xor | i_sll | i_srl | i_sra | i_sllv | i_srlv | i_srav
                     | i_jalr;
        // bgez carries 1 in rt, the immediates their dest
        dec.no_rt    = dec.wdest_rt | i_bgez | i_j | i_jal;
    end

endmodule

// ==== if_id_reg.sv ====
`timescale 1ns/10ps

module if_id_reg (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 fetch_valid,
    input  pipe_pkg::fetch_bus_t fetch,
    input  logic                 id_over,
    output logic                 id_valid,
    output pipe_pkg::fetch_bus_t id_inst,
    output logic                 id_allow_in
);

    logic load_en;

    assign id_allow_in = ~id_valid | id_over;   // empty, or leaving this cycle
    assign load_en     = fetch_valid & id_allow_in;

    // valid drops when the held inst completes with nothing behind it
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_valid <= 1'b0;
        end else if (id_allow_in) begin
            id_valid <= fetch_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load_en) begin
            id_inst <= fetch;   // held until id_over
        end
    end

endmodule

// ==== pipe_pkg.sv ====
package pipe_pkg;

    // fetch -> decode
    typedef struct packed {
        isa_pkg::word_t pc;
        isa_pkg::word_t inst;
    } fetch_bus_t;

    // decode -> fetch redirect
    typedef struct packed {
        logic           taken;
        isa_pkg::word_t target;
    } jbr_bus_t;

    // **************************************************
    // decoder class flags shared by the other submodules
    // **************************************************
    typedef struct packed {
        isa_pkg::alu_op_t alu_op;
        logic             imm_zero;   // zero-extend imm
        logic             imm_sign;   // sign-extend imm
        logic             shift_sa;   // shift amount from sa field
        logic             link;       // jal / jalr
        logic             jump_reg;   // jr / jalr
        logic             jump_abs;   // j / jal
        logic             beq;
        logic             bne;
        logic             bgez;
        logic             bgtz;
        logic             blez;
        logic             bltz;
        logic             wdest_rd;
        logic             wdest_rt;
        logic             wdest_31;
        logic             no_rt;      // rt field is not a source
    } dec_info_t;

    // decode -> execute
    typedef struct packed {
        isa_pkg::alu_op_t    alu_op;
        isa_pkg::word_t      operand1;
        isa_pkg::word_t      operand2;
        logic                rf_wen;
        isa_pkg::reg_addr_t  rf_wdest;
    } exe_bus_t;

endpackage

// ==== isa_pkg.sv ====
`include "mips_defines.svh"

package isa_pkg;

    typedef logic [`DATA_W-1:0]     word_t;      // data word or pc
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;  // gpr number
    typedef logic [`OPCODE_W-1:0]   opcode_t;    // inst[31:26]
    typedef logic [`FUNCT_W-1:0]    funct_t;     // inst[5:0]
    typedef logic [`IMM_W-1:0]      imm_t;       // immediate or branch offset

    // one-hot, msb first:
    // add sub slt sltu and nor or xor sll srl sra lui
    typedef logic [`ALU_OP_W-1:0]   alu_op_t;

endpackage

// ==== mips_defines.svh ====
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// **************************************************
// widths
// **************************************************
`define DATA_W      32      // word and pc
`define REG_ADDR_W  5       // gpr number
`define OPCODE_W    6
`define FUNCT_W     6
`define IMM_W       16
`define TARGET_W    26      // j/jal index field
`define ALU_OP_W    12      // one-hot alu control

`define LINK_REG    31      // jal writes here
`define LINK_OFFSET 8       // return past the delay slot

// **************************************************
// primary opcodes
// **************************************************
`define OP_SPECIAL  6'b000000
`define OP_REGIMM   6'b000001
`define OP_J        6'b000010
`define OP_JAL      6'b000011
`define OP_BEQ      6'b000100
`define OP_BNE      6'b000101
`define OP_BLEZ     6'b000110
`define OP_BGTZ     6'b000111
`define OP_ADDIU    6'b001001
`define OP_SLTI     6'b001010
`define OP_SLTIU    6'b001011
`define OP_ANDI     6'b001100
`define OP_ORI      6'b001101
`define OP_XORI     6'b001110
`define OP_LUI      6'b001111

// rt field selects the regimm branch
`define RT_BLTZ     5'b00000
`define RT_BGEZ     5'b00001

// **************************************************
// special funct codes
// **************************************************
`define FN_SLL      6'b000000
`define FN_SRL      6'b000010
`define FN_SRA      6'b000011
`define FN_SLLV     6'b000100
`define FN_SRLV     6'b000110
`define FN_SRAV     6'b000111
`define FN_JR       6'b001000
`define FN_JALR     6'b001001
`define FN_ADDU     6'b100001
`define FN_SUBU     6'b100011
`define FN_AND      6'b100100
`define FN_OR       6'b100101
`define FN_XOR      6'b100110
`define FN_NOR      6'b100111
`define FN_SLT      6'b101010
`define FN_SLTU     6'b101011

`endif
